// File: source/ray_gen_settings.svh
`ifndef RAY_GEN_SETTINGS_SVH
`define RAY_GEN_SETTINGS_SVH

// screen size in pixels, small enough for quick simulation
`define RG_NUM_COLS 16
`define RG_NUM_ROWS 12

// view plane corner in Q16.16
// left edge sits at -4.0 and top edge at -3.0
`define RG_HALF_W (-32'sh0004_0000)
`define RG_HALF_H (-32'sh0003_0000)

// distance from eye to view plane, 4.0 in Q16.16
`define RG_SCREEN_DIST (32'sh0004_0000)

`endif

// File: source/ray_gen_pkg.sv
`include "ray_gen_settings.svh"

package ray_gen_pkg;

	// signed Q16.16
	typedef logic signed [31:0] fix_t;

	typedef struct packed {
		fix_t x;
		fix_t y;
		fix_t z;
	} vec3_t;

	// last marks the final pixel of a frame
	typedef struct packed {
		logic [$clog2(`RG_NUM_COLS)-1:0] x;
		logic [$clog2(`RG_NUM_ROWS)-1:0] y;
		logic last;
	} pixel_t;

	typedef struct packed {
		fix_t u;
		fix_t v;
		pixel_t pix;
	} plane_uv_t;

	typedef struct packed {
		vec3_t origin;
		vec3_t dir;
	} ray_t;

	typedef struct packed {
		ray_t ray;
		pixel_t pix;
	} ray_out_t;

	// one cycle per axis while a pixel is processed
	typedef enum logic [1:0] {
		PH_X,
		PH_Y,
		PH_Z
	} axis_phase_t;

	// dropping the low 16 bits floors the product toward minus infinity
	function automatic fix_t fix_mul(input fix_t a, input fix_t b);
		logic signed [63:0] prod;
		prod = a * b;
		return prod[47:16];
	endfunction

endpackage

// File: source/pixel_scanner.sv
`include "ray_gen_settings.svh"

module pixel_scanner import ray_gen_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        start,
	output pixel_t      pix,
	output axis_phase_t phase,
	output logic        pix_valid,
	output logic        frame_start,
	output logic        busy
);

	typedef enum logic {
		SCAN_IDLE,
		SCAN_RUN
	} scan_state_t;

	scan_state_t state;
	pixel_t next_pix;

	// start is only honoured from idle
	assign frame_start = start && (state == SCAN_IDLE);
	assign pix_valid   = (state == SCAN_RUN);
	assign busy        = (state == SCAN_RUN);

	// next pixel in row-major order, or the first one when idle
	always_comb begin
		next_pix = '0;
		if (state == SCAN_RUN) begin
			if (pix.x == `RG_NUM_COLS - 1) begin
				next_pix.y = pix.y + 1'b1;
			end else begin
				next_pix.x = pix.x + 1'b1;
				next_pix.y = pix.y;
			end
		end
		next_pix.last = (next_pix.x == `RG_NUM_COLS - 1) &&
			(next_pix.y == `RG_NUM_ROWS - 1);
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= SCAN_IDLE;
			pix   <= '0;
			phase <= PH_X;
		end else begin
			case (state)
				SCAN_IDLE: begin
					if (frame_start) begin
						state <= SCAN_RUN;
						pix   <= next_pix;
						phase <= PH_X;
					end
				end
				default: begin
					case (phase)
						PH_X: phase <= PH_Y;
						PH_Y: phase <= PH_Z;
						default: begin
							phase <= PH_X;
							// frame ends after the z cycle of the last pixel
							if (pix.last) begin
								state <= SCAN_IDLE;
							end else begin
								pix <= next_pix;
							end
						end
					endcase
				end
			endcase
		end
	end

endmodule

// File: source/plane_coord_unit.sv
`include "ray_gen_settings.svh"

module plane_coord_unit import ray_gen_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  pixel_t      pix,
	input  axis_phase_t phase,
	input  logic        pix_valid,
	input  fix_t        pixel_width,
	output plane_uv_t   uv,
	output logic        uv_valid
);

	fix_t coord_q;
	fix_t offset;
	fix_t result;
	fix_t u_r;
	fix_t v_r;

	// x feeds the multiplier in the first phase, y in the others
	always_comb begin
		if (phase == PH_X) begin
			coord_q = fix_t'(pix.x) << 16;
			offset  = `RG_HALF_W;
		end else begin
			coord_q = fix_t'(pix.y) << 16;
			offset  = `RG_HALF_H;
		end
	end

	// single shared multiplier and adder
	assign result = fix_mul(coord_q, pixel_width) + offset;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			u_r <= '0;
			v_r <= '0;
		end else if (pix_valid) begin
			if (phase == PH_X) begin
				u_r <= result;
			end else if (phase == PH_Y) begin
				v_r <= result;
			end
		end
	end

	// u and v both settled by the z cycle
	assign uv_valid = pix_valid && (phase == PH_Z);
	assign uv.u     = u_r;
	assign uv.v     = v_r;
	assign uv.pix   = pix;

endmodule

// File: source/depth_offset_unit.sv
`include "ray_gen_settings.svh"

module depth_offset_unit import ray_gen_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  logic  frame_start,
	input  vec3_t basis_w,
	output vec3_t depth_off
);

	typedef enum logic [1:0] {
		DO_IDLE,
		DO_X,
		DO_Y,
		DO_Z
	} do_state_t;

	do_state_t state;
	do_state_t step;
	fix_t w_sel;
	fix_t prod;

	// x is handled in the start cycle itself
	assign step = frame_start ? DO_X : state;

	always_comb begin
		case (step)
			DO_X:    w_sel = basis_w.x;
			DO_Y:    w_sel = basis_w.y;
			default: w_sel = basis_w.z;
		endcase
	end

	assign prod = fix_mul(w_sel, `RG_SCREEN_DIST);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state     <= DO_IDLE;
			depth_off <= '0;
		end else begin
			case (step)
				DO_X: begin
					depth_off.x <= prod;
					state       <= DO_Y;
				end
				DO_Y: begin
					depth_off.y <= prod;
					state       <= DO_Z;
				end
				DO_Z: begin
					depth_off.z <= prod;
					state       <= DO_IDLE;
				end
				default: state <= DO_IDLE;
			endcase
		end
	end

endmodule

// File: source/ray_dir_combiner.sv
module ray_dir_combiner import ray_gen_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  plane_uv_t uv,
	input  logic      uv_valid,
	input  vec3_t     eye,
	input  vec3_t     basis_u,
	input  vec3_t     basis_v,
	input  vec3_t     depth_off,
	output ray_out_t  ray_out,
	output logic      ray_ready,
	output logic      frame_done
);

	axis_phase_t ph;
	axis_phase_t axis;
	plane_uv_t uv_r;
	vec3_t dir_r;
	logic calc;
	fix_t u_sel;
	fix_t v_sel;
	fix_t bu;
	fix_t bv;
	fix_t bw;
	fix_t uv_sum;
	fix_t dir_axis;

	// x uses the incoming pair directly, y and z use the held copy
	assign calc  = uv_valid || (ph != PH_X);
	assign axis  = uv_valid ? PH_X : ph;
	assign u_sel = uv_valid ? uv.u : uv_r.u;
	assign v_sel = uv_valid ? uv.v : uv_r.v;

	always_comb begin
		case (axis)
			PH_X: begin
				bu = basis_u.x;
				bv = basis_v.x;
				bw = depth_off.x;
			end
			PH_Y: begin
				bu = basis_u.y;
				bv = basis_v.y;
				bw = depth_off.y;
			end
			default: begin
				bu = basis_u.z;
				bv = basis_v.z;
				bw = depth_off.z;
			end
		endcase
	end

	// u*U + v*V + D*W for the selected axis, sums wrap
	assign uv_sum   = fix_mul(u_sel, bu) + fix_mul(v_sel, bv);
	assign dir_axis = uv_sum + bw;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ph         <= PH_X;
			uv_r       <= '0;
			dir_r      <= '0;
			ray_ready  <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			ray_ready  <= 1'b0;
			frame_done <= 1'b0;
			if (uv_valid) begin
				uv_r <= uv;
			end
			if (calc) begin
				case (axis)
					PH_X: begin
						dir_r.x <= dir_axis;
						ph      <= PH_Y;
					end
					PH_Y: begin
						dir_r.y <= dir_axis;
						ph      <= PH_Z;
					end
					default: begin
						dir_r.z    <= dir_axis;
						ph         <= PH_X;
						ray_ready  <= 1'b1;
						frame_done <= uv_r.pix.last;
					end
				endcase
			end
		end
	end

	// dir and pixel stay intact until the next pixel's x cycle ends
	assign ray_out.ray.origin = eye;
	assign ray_out.ray.dir    = dir_r;
	assign ray_out.pix        = uv_r.pix;

endmodule

// File: source/ray_gen_top.sv
module ray_gen_top import ray_gen_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     start,
	input  vec3_t    eye,
	input  vec3_t    basis_u,
	input  vec3_t    basis_v,
	input  vec3_t    basis_w,
	input  fix_t     pixel_width,
	output logic     busy,
	output logic     ray_ready,
	output logic     frame_done,
	output ray_out_t ray_out
);

	pixel_t pix;
	axis_phase_t phase;
	logic pix_valid;
	logic frame_start;
	plane_uv_t uv;
	logic uv_valid;
	vec3_t depth_off;

	pixel_scanner scanner (
		.clk,
		.rst,
		.start,
		.pix,
		.phase,
		.pix_valid,
		.frame_start,
		.busy
	);

	// per pixel
	plane_coord_unit plane_unit (
		.clk,
		.rst,
		.pix,
		.phase,
		.pix_valid,
		.pixel_width,
		.uv,
		.uv_valid
	);

	// per frame, ready before the first uv pair arrives
	depth_offset_unit depth_unit (
		.clk,
		.rst,
		.frame_start,
		.basis_w,
		.depth_off
	);

	ray_dir_combiner combiner (
		.clk,
		.rst,
		.uv,
		.uv_valid,
		.eye,
		.basis_u,
		.basis_v,
		.depth_off,
		.ray_out,
		.ray_ready,
		.frame_done
	);

endmodule

// File: bench/tb_clock_gen.sv
module tb_clock_gen (
	output logic clk,
	output logic rst
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam int HALF_PERIOD = 4;

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	// reset held over the first two rising edges
	initial begin
		rst = 1'b1;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

// File: bench/ray_gen_tb.sv
`include "ray_gen_settings.svh"

module ray_gen_tb import ray_gen_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int PIXELS = `RG_NUM_COLS * `RG_NUM_ROWS;
	localparam int NUM_FRAMES = 5;
	localparam int CLK_PERIOD = 8;
	localparam int WATCHDOG_CYCLES = NUM_FRAMES * (PIXELS * 3 + 20) + 50;

	typedef struct packed {
		vec3_t eye;
		vec3_t u;
		vec3_t v;
		vec3_t w;
		fix_t pw;
	} camera_t;

	logic clk;
	logic rst;
	logic start;
	camera_t cam;
	logic busy;
	logic ray_ready;
	logic frame_done;
	ray_out_t ray_out;

	// monitor state, one frame at a time
	camera_t frame_cam;
	logic active;
	int cyc;
	int start_cyc;
	int ray_idx;
	int rays_seen;
	int frames_started;
	int frames_done;
	int ignored_starts;
	int checks;
	int errors;
	int tests_failed;

	tb_clock_gen clock_gen (
		.clk,
		.rst
	);

	ray_gen_top UUT (
		.clk,
		.rst,
		.start,
		.eye(cam.eye),
		.basis_u(cam.u),
		.basis_v(cam.v),
		.basis_w(cam.w),
		.pixel_width(cam.pw),
		.busy,
		.ray_ready,
		.frame_done,
		.ray_out
	);

	// exact floor of the Q16.16 product
	function automatic fix_t q16_product(input fix_t a, input fix_t b);
		longint full;
		full = longint'(a) * longint'(b);
		return fix_t'(full >>> 16);
	endfunction

	function automatic vec3_t expected_dir(input camera_t c, input int col, input int row);
		fix_t u;
		fix_t v;
		vec3_t d;
		// whole pixel indices, so x*pw is exact
		u = col * c.pw + `RG_HALF_W;
		v = row * c.pw + `RG_HALF_H;
		d.x = q16_product(u, c.u.x) + q16_product(v, c.v.x) +
			q16_product(c.w.x, `RG_SCREEN_DIST);
		d.y = q16_product(u, c.u.y) + q16_product(v, c.v.y) +
			q16_product(c.w.y, `RG_SCREEN_DIST);
		d.z = q16_product(u, c.u.z) + q16_product(v, c.v.z) +
			q16_product(c.w.z, `RG_SCREEN_DIST);
		return d;
	endfunction

	function automatic fix_t random_fix(input int lo, input int hi);
		return fix_t'($urandom_range(hi - lo, 0)) + lo;
	endfunction

	// values within +-4.0
	function automatic vec3_t random_vec();
		vec3_t r;
		r.x = random_fix(-262144, 262144);
		r.y = random_fix(-262144, 262144);
		r.z = random_fix(-262144, 262144);
		return r;
	endfunction

	function automatic camera_t draw_camera();
		camera_t c;
		c.eye = random_vec();
		c.u = random_vec();
		c.v = random_vec();
		c.w = random_vec();
		c.pw = random_fix(16384, 65536);
		return c;
	endfunction

	task automatic compare_word(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("mismatch at %0d ns: %s expected %h, actual %h",
				$time, name, expected, actual);
		end
	endtask

	task automatic check_ray();
		int col;
		int row;
		vec3_t dir;
		col = ray_idx % `RG_NUM_COLS;
		row = ray_idx / `RG_NUM_COLS;
		dir = expected_dir(frame_cam, col, row);
		compare_word("ray_ready", 1, ray_ready);
		compare_word("ray_out.pix.x", col, ray_out.pix.x);
		compare_word("ray_out.pix.y", row, ray_out.pix.y);
		compare_word("ray_out.pix.last", ray_idx == PIXELS - 1, ray_out.pix.last);
		compare_word("frame_done", ray_idx == PIXELS - 1, frame_done);
		compare_word("ray_out.ray.origin.x", frame_cam.eye.x, ray_out.ray.origin.x);
		compare_word("ray_out.ray.origin.y", frame_cam.eye.y, ray_out.ray.origin.y);
		compare_word("ray_out.ray.origin.z", frame_cam.eye.z, ray_out.ray.origin.z);
		compare_word("ray_out.ray.dir.x", dir.x, ray_out.ray.dir.x);
		compare_word("ray_out.ray.dir.y", dir.y, ray_out.ray.dir.y);
		compare_word("ray_out.ray.dir.z", dir.z, ray_out.ray.dir.z);
		rays_seen++;
		ray_idx++;
		if (ray_idx == PIXELS) begin
			active = 1'b0;
		end
	endtask

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	// outputs are sampled half a cycle after the driving edge
	always @(negedge clk) begin
		logic exp_busy;
		if (!rst) begin
			if (frame_done === 1'b1) begin
				frames_done++;
			end
			if (start && busy) begin
				ignored_starts++;
			end
			if (start && !busy) begin
				if (active) begin
					errors++;
					$display("start accepted at %0d ns before the last frame ended", $time);
				end
				active = 1'b1;
				frame_cam = cam;
				start_cyc = cyc;
				ray_idx = 0;
				frames_started++;
			end else if (active && (cyc == start_cyc + 6 + 3 * ray_idx)) begin
				check_ray();
			end else begin
				compare_word("ray_ready", 0, ray_ready);
				compare_word("frame_done", 0, frame_done);
			end
			exp_busy = active && (cyc > start_cyc) && (cyc <= start_cyc + 3 * PIXELS);
			compare_word("busy", exp_busy, busy);
		end
	end

	// one random camera, optionally with a second start pulse mid-frame
	task automatic run_frame(input logic poke);
		@(posedge clk);
		cam <= draw_camera();
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		if (poke) begin
			repeat (40) @(posedge clk);
			start <= 1'b1;
			@(posedge clk);
			start <= 1'b0;
		end
		do begin
			@(negedge clk);
		end while (frame_done !== 1'b1);
	endtask

	task automatic report_test(input int num, input string name, input int err_before,
		input int rays_before);
		int err;
		@(posedge clk);
		err = errors - err_before;
		$display("test %0d %s: %s, %0d rays, %0d errors", num, name,
			(err == 0) ? "ok" : "failed", rays_seen - rays_before, err);
		if (err != 0) begin
			tests_failed++;
		end
	endtask

	initial begin
		int err0;
		int rays0;
		void'($urandom(54));
		start = 1'b0;
		cam = '0;
		active = 1'b0;
		cyc = 0;
		start_cyc = 0;
		ray_idx = 0;
		rays_seen = 0;
		frames_started = 0;
		frames_done = 0;
		ignored_starts = 0;
		checks = 0;
		errors = 0;
		tests_failed = 0;

		err0 = errors;
		rays0 = rays_seen;
		wait (rst === 1'b0);
		repeat (10) @(negedge clk);
		report_test(1, "reset_idle", err0, rays0);

		err0 = errors;
		rays0 = rays_seen;
		run_frame(1'b0);
		report_test(2, "single_frame", err0, rays0);

		err0 = errors;
		rays0 = rays_seen;
		run_frame(1'b1);
		if (ignored_starts != 1) begin
			errors++;
			$display("the start pulse sent during a frame was not seen while busy");
		end
		report_test(3, "start_while_busy", err0, rays0);

		// next frame starts right after frame_done with a fresh camera
		err0 = errors;
		rays0 = rays_seen;
		repeat (3) run_frame(1'b0);
		repeat (5) @(posedge clk);
		if ((frames_started != NUM_FRAMES) || (frames_done != NUM_FRAMES)) begin
			errors++;
			$display("frames started %0d and frame_done pulses %0d, expected %0d each",
				frames_started, frames_done, NUM_FRAMES);
		end
		report_test(4, "back_to_back", err0, rays0);

		$display("4 tests, %0d failed, %0d checks, %0d errors", tests_failed, checks, errors);
		if ((errors == 0) && (tests_failed == 0)) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// File: sim.f
+incdir+source
source/ray_gen_pkg.sv
source/pixel_scanner.sv
source/plane_coord_unit.sv
source/depth_offset_unit.sv
source/ray_dir_combiner.sv
source/ray_gen_top.sv
bench/tb_clock_gen.sv
bench/ray_gen_tb.sv

// File: Bender.yml
package:
  name: ray_gen

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/ray_gen_pkg.sv
      - source/pixel_scanner.sv
      - source/plane_coord_unit.sv
      - source/depth_offset_unit.sv
      - source/ray_dir_combiner.sv
      - source/ray_gen_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - bench/tb_clock_gen.sv
      - bench/ray_gen_tb.sv
